// File: list.f
mipsOiscPkg.sv
translateControl.sv
mipsDecoder.sv
moveComposer.sv
mipsOisc.sv
tbMipsOisc.sv

// File: mipsDecoder.sv
`timescale 1ns/10ps
`default_nettype none

module mipsDecoder (
  input  mipsOiscPkg::mipsInstr instr,
  output mipsOiscPkg::decodedOp op
);

  logic [mipsOiscPkg::mipsWordW-1:0] word;
  logic constShift;
  logic toHiLo;
  mipsOiscPkg::oiscAddr hiLoReg;

  assign word = instr;

  function automatic mipsOiscPkg::decodedOp pick(
    input mipsOiscPkg::oiscAddr base,
    input mipsOiscPkg::seqClass cls,
    input logic [1:0]           lit
  );
    mipsOiscPkg::decodedOp d;
    d           = '0;
    d.unitBase  = base;
    d.cls       = cls;
    d.ctrlLit   = lit;
    d.stepCount = mipsOiscPkg::seqSteps(cls);
    return d;
  endfunction

  // funct bit 0 gives the direction, bit 1 picks LO
  assign toHiLo  = instr.rView.funct[0];
  assign hiLoReg = instr.rView.funct[1] ? mipsOiscPkg::loAddr : mipsOiscPkg::hiAddr;

  always_comb begin
    op = pick(16'h0000, mipsOiscPkg::nopSeq, 2'b00);
    casez (word)
      32'b000000_?????_?????_?????_00000_100100:  // AND
        op = pick(mipsOiscPkg::andBase, mipsOiscPkg::threeRegSimple, 2'b00);
      32'b000000_?????_?????_?????_00000_100101:  // OR
        op = pick(mipsOiscPkg::orBase, mipsOiscPkg::threeRegSimple, 2'b00);
      32'b000000_?????_?????_?????_00000_100110:  // XOR
        op = pick(mipsOiscPkg::xorBase, mipsOiscPkg::threeRegSimple, 2'b00);
      32'b000000_?????_?????_?????_00000_100111:  // NOR
        op = pick(mipsOiscPkg::norBase, mipsOiscPkg::threeRegSimple, 2'b00);
      32'b000000_?????_?????_?????_00000_101010:  // SLT
        op = pick(mipsOiscPkg::sltBase, mipsOiscPkg::threeRegSimple, 2'b00);
      32'b000000_?????_?????_?????_00000_101011:  // SLTU
        op = pick(mipsOiscPkg::sltuBase, mipsOiscPkg::threeRegSimple, 2'b00);
      32'b001100_?????_?????_?????_?????_??????:  // ANDI
        op = pick(mipsOiscPkg::andBase, mipsOiscPkg::immSimple, 2'b00);
      32'b001101_?????_?????_?????_?????_??????:  // ORI
        op = pick(mipsOiscPkg::orBase, mipsOiscPkg::immSimple, 2'b00);
      32'b001110_?????_?????_?????_?????_??????:  // XORI
        op = pick(mipsOiscPkg::xorBase, mipsOiscPkg::immSimple, 2'b00);
      32'b001010_?????_?????_?????_?????_??????:  // SLTI
        op = pick(mipsOiscPkg::sltBase, mipsOiscPkg::immSimple, 2'b00);
      32'b001011_?????_?????_?????_?????_??????:  // SLTIU
        op = pick(mipsOiscPkg::sltuBase, mipsOiscPkg::immSimple, 2'b00);
      32'b000000_?????_?????_?????_00000_100000:  // ADD
        op = pick(mipsOiscPkg::addBase, mipsOiscPkg::threeRegCtrl, mipsOiscPkg::addTrap);
      32'b000000_?????_?????_?????_00000_100001:  // ADDU
        op = pick(mipsOiscPkg::addBase, mipsOiscPkg::threeRegCtrl, 2'b00);
      32'b000000_?????_?????_?????_00000_100010:  // SUB
        op = pick(mipsOiscPkg::addBase, mipsOiscPkg::threeRegCtrl,
                  mipsOiscPkg::addSub | mipsOiscPkg::addTrap);
      32'b000000_?????_?????_?????_00000_100011:  // SUBU
        op = pick(mipsOiscPkg::addBase, mipsOiscPkg::threeRegCtrl, mipsOiscPkg::addSub);
      32'b001000_?????_?????_?????_?????_??????:  // ADDI
        op = pick(mipsOiscPkg::addBase, mipsOiscPkg::immCtrl, mipsOiscPkg::addTrap);
      32'b001001_?????_?????_?????_?????_??????:  // ADDIU
        op = pick(mipsOiscPkg::addBase, mipsOiscPkg::immCtrl, 2'b00);
      32'b000000_00000_?????_?????_?????_000000:  // SLL
        op = pick(mipsOiscPkg::shiftBase, mipsOiscPkg::immCtrl, mipsOiscPkg::shiftLeft);
      32'b000000_00000_?????_?????_?????_000010:  // SRL
        op = pick(mipsOiscPkg::shiftBase, mipsOiscPkg::immCtrl, 2'b00);
      32'b000000_00000_?????_?????_?????_000011:  // SRA
        op = pick(mipsOiscPkg::shiftBase, mipsOiscPkg::immCtrl, mipsOiscPkg::shiftArith);
      32'b000000_?????_?????_?????_00000_000100:  // SLLV
        op = pick(mipsOiscPkg::shiftBase, mipsOiscPkg::threeRegCtrl, mipsOiscPkg::shiftLeft);
      32'b000000_?????_?????_?????_00000_000110:  // SRLV
        op = pick(mipsOiscPkg::shiftBase, mipsOiscPkg::threeRegCtrl, 2'b00);
      32'b000000_?????_?????_?????_00000_000111:  // SRAV
        op = pick(mipsOiscPkg::shiftBase, mipsOiscPkg::threeRegCtrl, mipsOiscPkg::shiftArith);
      32'b000000_?????_?????_00000_00000_011000:  // MULT
        op = pick(mipsOiscPkg::multBase, mipsOiscPkg::hiLo, mipsOiscPkg::mdSigned);
      32'b000000_?????_?????_00000_00000_011001:  // MULTU
        op = pick(mipsOiscPkg::multBase, mipsOiscPkg::hiLo, 2'b00);
      32'b000000_?????_?????_00000_00000_011010:  // DIV
        op = pick(mipsOiscPkg::divBase, mipsOiscPkg::hiLo, mipsOiscPkg::mdSigned);
      32'b000000_?????_?????_00000_00000_011011:  // DIVU
        op = pick(mipsOiscPkg::divBase, mipsOiscPkg::hiLo, 2'b00);
      32'b000000_00000_00000_?????_00000_0100?0,  // MFHI, MFLO
      32'b000000_?????_00000_00000_00000_0100?1:  // MTHI, MTLO
        op = pick(16'h0000, mipsOiscPkg::moveHiLo, 2'b00);
      32'b001111_00000_?????_?????_?????_??????:  // LUI
        op = pick(mipsOiscPkg::luiBase, mipsOiscPkg::lui, 2'b00);
      default: ;
    endcase

    constShift = (op.cls == mipsOiscPkg::immCtrl) &&
                 (op.unitBase == mipsOiscPkg::shiftBase);

    // Constant shifts work on rt with shamt
    op.accFromRt  = constShift;
    op.immIsShamt = constShift;
    op.destIsRd   = constShift ||
                    (op.cls == mipsOiscPkg::threeRegSimple) ||
                    (op.cls == mipsOiscPkg::threeRegCtrl);

    if (op.cls == mipsOiscPkg::moveHiLo) begin
      op.moveSrc = toHiLo ? mipsOiscPkg::gprAddr(instr.rView.rs) : hiLoReg;
      op.moveDst = toHiLo ? hiLoReg : mipsOiscPkg::gprAddr(instr.rView.rd);
    end
  end

endmodule

`default_nettype wire

// File: mipsOisc.sv
`timescale 1ns/10ps
`default_nettype none

module mipsOisc (
  input  logic                  CLK,
  input  logic                  RST,

  input  logic                  inValid,
  output logic                  inReady,
  input  mipsOiscPkg::mipsInstr inData,

  output logic                  outValid,
  input  logic                  outReady,
  output mipsOiscPkg::oiscMove  outData
);

  mipsOiscPkg::mipsInstr instr;
  mipsOiscPkg::stepIdx   step;
  mipsOiscPkg::decodedOp op;

  translateControl uControl (
    .CLK       (CLK),
    .RST       (RST),
    .inValid   (inValid),
    .inReady   (inReady),
    .inData    (inData),
    .outValid  (outValid),
    .outReady  (outReady),
    .stepCount (op.stepCount),
    .instr     (instr),
    .step      (step)
  );

  mipsDecoder uDecoder (
    .instr (instr),
    .op    (op)
  );

  moveComposer uComposer (
    .instr   (instr),
    .op      (op),
    .step    (step),
    .outData (outData)
  );

endmodule

`default_nettype wire

// File: mipsOiscPkg.sv
`default_nettype none

package mipsOiscPkg;

  localparam int mipsWordW  = 32;
  localparam int oiscFieldW = 16;

  typedef logic [oiscFieldW-1:0] oiscAddr;
  typedef logic [2:0] stepIdx;

  // Same MIPS word seen as R-type or I-type
  typedef struct packed {
    logic [5:0] opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    logic [5:0] funct;
  } rFormat;

  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] imm;
  } iFormat;

  typedef union packed {
    rFormat rView;
    iFormat iView;
  } mipsInstr;

  typedef struct packed {
    oiscAddr src; // Address or literal, dst decides
    oiscAddr dst;
  } oiscMove;

  // Fixed locations
  localparam oiscAddr hiAddr  = 16'h0010;
  localparam oiscAddr loAddr  = 16'h0011;
  localparam oiscAddr immAddr = 16'h0012; // Literal sink
  localparam oiscAddr gprBase = 16'h0020;

  localparam oiscAddr andBase   = 16'h0100;
  localparam oiscAddr orBase    = 16'h0110;
  localparam oiscAddr xorBase   = 16'h0120;
  localparam oiscAddr norBase   = 16'h0130;
  localparam oiscAddr sltBase   = 16'h0140;
  localparam oiscAddr sltuBase  = 16'h0150;
  localparam oiscAddr addBase   = 16'h0160;
  localparam oiscAddr shiftBase = 16'h0170;
  localparam oiscAddr multBase  = 16'h0180;
  localparam oiscAddr divBase   = 16'h0190;
  localparam oiscAddr luiBase   = 16'h01A0;

  // Registers inside each unit window
  localparam oiscAddr accOfs   = 16'd0;
  localparam oiscAddr opndOfs  = 16'd1;
  localparam oiscAddr ctrlOfs  = 16'd2;
  localparam oiscAddr resOfs   = 16'd3;
  localparam oiscAddr resHiOfs = 16'd4;

  localparam logic [1:0] addTrap    = 2'b01; // Overflow trap
  localparam logic [1:0] addSub     = 2'b10;
  localparam logic [1:0] shiftArith = 2'b01;
  localparam logic [1:0] shiftLeft  = 2'b10;
  localparam logic [1:0] mdSigned   = 2'b01; // Multiplier and divider

  typedef enum logic [2:0] {
    nopSeq         = 3'd0,
    threeRegSimple = 3'd1,
    immSimple      = 3'd2,
    threeRegCtrl   = 3'd3,
    immCtrl        = 3'd4,
    hiLo           = 3'd5,
    moveHiLo       = 3'd6,
    lui            = 3'd7
  } seqClass;

  localparam stepIdx maxSteps = 3'd5;

  typedef struct packed {
    oiscAddr    unitBase;
    seqClass    cls;
    logic [1:0] ctrlLit;
    logic       accFromRt;
    logic       immIsShamt;
    logic       destIsRd;
    oiscAddr    moveSrc;
    oiscAddr    moveDst;
    stepIdx     stepCount;
  } decodedOp;

  // Moves emitted per class
  function automatic stepIdx seqSteps(input seqClass cls);
    case (cls)
      threeRegSimple: return 3'd3;
      immSimple:      return 3'd4;
      threeRegCtrl:   return 3'd4;
      immCtrl:        return 3'd5;
      hiLo:           return 3'd5;
      lui:            return 3'd3;
      default:        return 3'd1;
    endcase
  endfunction

  function automatic oiscAddr gprAddr(input logic [4:0] r);
    return gprBase + {11'b0, r};
  endfunction

endpackage

`default_nettype wire

// File: moveComposer.sv
`timescale 1ns/10ps
`default_nettype none

module moveComposer (
  input  mipsOiscPkg::mipsInstr instr,
  input  mipsOiscPkg::decodedOp op,
  input  mipsOiscPkg::stepIdx   step,
  output mipsOiscPkg::oiscMove  outData
);

  mipsOiscPkg::oiscAddr srcReg;
  mipsOiscPkg::oiscAddr tmpReg;
  mipsOiscPkg::oiscAddr destReg;
  mipsOiscPkg::oiscAddr accSrc;
  mipsOiscPkg::oiscAddr immVal;
  mipsOiscPkg::oiscAddr ctrlVal;
  mipsOiscPkg::oiscAddr unitAcc;
  mipsOiscPkg::oiscAddr unitOpnd;
  mipsOiscPkg::oiscAddr unitCtrl;
  mipsOiscPkg::oiscAddr unitRes;
  mipsOiscPkg::oiscAddr unitResHi;

  // GPR window
  assign srcReg  = mipsOiscPkg::gprAddr(instr.rView.rs);
  assign tmpReg  = mipsOiscPkg::gprAddr(instr.rView.rt);
  assign destReg = op.destIsRd ? mipsOiscPkg::gprAddr(instr.rView.rd) : tmpReg;
  assign accSrc  = op.accFromRt ? tmpReg : srcReg;

  assign immVal  = op.immIsShamt ? {11'b0, instr.rView.shamt} : instr.iView.imm;
  assign ctrlVal = {14'b0, op.ctrlLit};

  assign unitAcc   = op.unitBase + mipsOiscPkg::accOfs;
  assign unitOpnd  = op.unitBase + mipsOiscPkg::opndOfs;
  assign unitCtrl  = op.unitBase + mipsOiscPkg::ctrlOfs;
  assign unitRes   = op.unitBase + mipsOiscPkg::resOfs;
  assign unitResHi = op.unitBase + mipsOiscPkg::resHiOfs;

  always_comb begin
    outData = '0;
    case (op.cls)
      mipsOiscPkg::threeRegSimple:
        case (step)
          3'd0:    outData = '{srcReg, unitAcc};
          3'd1:    outData = '{tmpReg, unitOpnd};
          3'd2:    outData = '{unitRes, destReg};
          default: outData = '0;
        endcase
      mipsOiscPkg::immSimple:
        case (step)
          3'd0:    outData = '{srcReg, unitAcc};
          3'd1:    outData = '{immVal, mipsOiscPkg::immAddr}; // Literal load
          3'd2:    outData = '{mipsOiscPkg::immAddr, unitOpnd};
          3'd3:    outData = '{unitRes, destReg};
          default: outData = '0;
        endcase
      mipsOiscPkg::threeRegCtrl:
        case (step)
          3'd0:    outData = '{srcReg, unitAcc};
          3'd1:    outData = '{tmpReg, unitOpnd};
          3'd2:    outData = '{ctrlVal, unitCtrl};
          3'd3:    outData = '{unitRes, destReg};
          default: outData = '0;
        endcase
      mipsOiscPkg::immCtrl:
        case (step)
          3'd0:    outData = '{accSrc, unitAcc};
          3'd1:    outData = '{immVal, mipsOiscPkg::immAddr};
          3'd2:    outData = '{mipsOiscPkg::immAddr, unitOpnd};
          3'd3:    outData = '{ctrlVal, unitCtrl};
          3'd4:    outData = '{unitRes, destReg};
          default: outData = '0;
        endcase
      mipsOiscPkg::hiLo:
        case (step)
          3'd0:    outData = '{srcReg, unitAcc};
          3'd1:    outData = '{tmpReg, unitOpnd};
          3'd2:    outData = '{ctrlVal, unitCtrl};
          3'd3:    outData = '{unitRes, mipsOiscPkg::loAddr};
          3'd4:    outData = '{unitResHi, mipsOiscPkg::hiAddr};
          default: outData = '0;
        endcase
      mipsOiscPkg::moveHiLo:
        outData = '{op.moveSrc, op.moveDst};
      mipsOiscPkg::lui:
        case (step)
          3'd0:    outData = '{immVal, mipsOiscPkg::immAddr};
          3'd1:    outData = '{mipsOiscPkg::immAddr, unitAcc};
          3'd2:    outData = '{unitRes, destReg};
          default: outData = '0;
        endcase
      default: outData = '0; // Unmatched word
    endcase
  end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build and run the MIPS to OISC translator testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing -f list.f --top-module tbMipsOisc -o simMipsOisc
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/simMipsOisc > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^Finished with no errors$" sim.log; then
  exit 0
fi
exit 1

// File: tbMipsOisc.sv
`timescale 1ns/10ps
`default_nettype none

module tbMipsOisc;

  localparam int numInstr  = 2000;
  localparam int maxMoves  = 5;
  localparam int clkPeriod = 100;
  localparam longint watchdogNs = longint'(numInstr) * maxMoves * 16 * clkPeriod;

  // AND OR XOR NOR SLT SLTU, ADD ADDU SUB SUBU, SLLV SRLV SRAV
  localparam logic [5:0] regFuncts [13] = '{6'h24, 6'h25, 6'h26, 6'h27, 6'h2a, 6'h2b,
                                            6'h20, 6'h21, 6'h22, 6'h23, 6'h04, 6'h06, 6'h07};
  localparam logic [5:0] immOpcodes [7] = '{6'h0c, 6'h0d, 6'h0e, 6'h0a, 6'h0b, 6'h08, 6'h09};
  localparam logic [5:0] shiftFuncts [3] = '{6'h00, 6'h02, 6'h03}; // SLL SRL SRA

  logic                  CLK;
  logic                  RST;
  logic                  inValid;
  logic                  inReady;
  mipsOiscPkg::mipsInstr inData;
  logic                  outValid;
  logic                  outReady;
  mipsOiscPkg::oiscMove  outData;

  logic [31:0] expQ [$]; // Expected moves, source in the upper half
  int errors;
  int checks;

  mipsOisc i_dut (
    .CLK      (CLK),
    .RST      (RST),
    .inValid  (inValid),
    .inReady  (inReady),
    .inData   (inData),
    .outValid (outValid),
    .outReady (outReady),
    .outData  (outData)
  );

  always #(clkPeriod / 2) CLK = ~CLK;

  task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic pushMove(input logic [15:0] src, input logic [15:0] dst);
    expQ.push_back({src, dst});
  endtask

  function automatic logic [31:0] randomInstr();
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [4:0]  sh;
    logic [15:0] imm;
    logic [31:0] w;
    rs  = 5'($urandom);
    rt  = 5'($urandom);
    rd  = 5'($urandom);
    sh  = 5'($urandom);
    imm = 16'($urandom);
    case ($urandom % 10)
      0, 1, 2: w = {6'h00, rs, rt, rd, 5'd0, regFuncts[4'($urandom % 13)]};
      3, 4:    w = {immOpcodes[3'($urandom % 7)], rs, rt, imm};
      5:       w = {6'h00, 5'd0, rt, rd, sh, shiftFuncts[2'($urandom % 3)]};
      6:       w = {6'h00, rs, rt, 10'd0, 4'b0110, 2'($urandom)}; // MULT to DIVU
      7:       w = ($urandom % 2) ? {6'h00, 10'd0, rd, 5'd0, 4'b0100, 1'($urandom), 1'b0}
                                  : {6'h00, rs, 15'd0, 4'b0100, 1'($urandom), 1'b1};
      8:       w = {6'h0f, 5'd0, rt, imm}; // LUI
      default: w = $urandom;
    endcase
    return w;
  endfunction

  // Expected move list of one MIPS word
  task automatic buildExpected(input logic [31:0] w);
    logic [5:0]  opc;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [4:0]  sh;
    logic [5:0]  fn;
    logic [15:0] imm;
    logic [15:0] regS;
    logic [15:0] regT;
    logic [15:0] regD;
    logic [15:0] base;
    logic [15:0] lit;
    opc  = w[31:26];
    rs   = w[25:21];
    rt   = w[20:16];
    rd   = w[15:11];
    sh   = w[10:6];
    fn   = w[5:0];
    imm  = w[15:0];
    regS = mipsOiscPkg::gprBase + {11'b0, rs};
    regT = mipsOiscPkg::gprBase + {11'b0, rt};
    regD = mipsOiscPkg::gprBase + {11'b0, rd};
    if (opc == 6'h00 && sh == 5'd0 && fn inside {6'h24, 6'h25, 6'h26, 6'h27, 6'h2a, 6'h2b}) begin
      case (fn)
        6'h24:   base = mipsOiscPkg::andBase;
        6'h25:   base = mipsOiscPkg::orBase;
        6'h26:   base = mipsOiscPkg::xorBase;
        6'h27:   base = mipsOiscPkg::norBase;
        6'h2a:   base = mipsOiscPkg::sltBase;
        default: base = mipsOiscPkg::sltuBase;
      endcase
      pushMove(regS, base);
      pushMove(regT, base + 16'd1);
      pushMove(base + 16'd3, regD);
    end else if (opc inside {6'h0c, 6'h0d, 6'h0e, 6'h0a, 6'h0b}) begin
      case (opc)
        6'h0c:   base = mipsOiscPkg::andBase;
        6'h0d:   base = mipsOiscPkg::orBase;
        6'h0e:   base = mipsOiscPkg::xorBase;
        6'h0a:   base = mipsOiscPkg::sltBase;
        default: base = mipsOiscPkg::sltuBase;
      endcase
      pushMove(regS, base);
      pushMove(imm, mipsOiscPkg::immAddr);
      pushMove(mipsOiscPkg::immAddr, base + 16'd1);
      pushMove(base + 16'd3, regT);
    end else if (opc == 6'h00 && sh == 5'd0 &&
                 fn inside {6'h20, 6'h21, 6'h22, 6'h23, 6'h04, 6'h06, 6'h07}) begin
      if (fn[5]) begin
        base = mipsOiscPkg::addBase;
        lit  = {14'b0, fn[1], ~fn[0]}; // Subtract, trap
      end else begin
        base = mipsOiscPkg::shiftBase;
        lit  = {14'b0, ~fn[1], fn[0]}; // Left, arithmetic
      end
      pushMove(regS, base);
      pushMove(regT, base + 16'd1);
      pushMove(lit, base + 16'd2);
      pushMove(base + 16'd3, regD);
    end else if (opc == 6'h08 || opc == 6'h09) begin
      base = mipsOiscPkg::addBase;
      lit  = {15'b0, ~opc[0]}; // ADDI traps
      pushMove(regS, base);
      pushMove(imm, mipsOiscPkg::immAddr);
      pushMove(mipsOiscPkg::immAddr, base + 16'd1);
      pushMove(lit, base + 16'd2);
      pushMove(base + 16'd3, regT);
    end else if (opc == 6'h00 && rs == 5'd0 && fn inside {6'h00, 6'h02, 6'h03}) begin
      base = mipsOiscPkg::shiftBase;
      lit  = {14'b0, ~fn[1], fn[0]};
      pushMove(regT, base);
      pushMove({11'b0, sh}, mipsOiscPkg::immAddr);
      pushMove(mipsOiscPkg::immAddr, base + 16'd1);
      pushMove(lit, base + 16'd2);
      pushMove(base + 16'd3, regD);
    end else if (opc == 6'h00 && rd == 5'd0 && sh == 5'd0 && fn[5:2] == 4'b0110) begin
      base = fn[1] ? mipsOiscPkg::divBase : mipsOiscPkg::multBase;
      lit  = {15'b0, ~fn[0]}; // Signed
      pushMove(regS, base);
      pushMove(regT, base + 16'd1);
      pushMove(lit, base + 16'd2);
      pushMove(base + 16'd3, mipsOiscPkg::loAddr);
      pushMove(base + 16'd4, mipsOiscPkg::hiAddr);
    end else if (opc == 6'h00 && rs == 5'd0 && rt == 5'd0 && sh == 5'd0 &&
                 fn[5:2] == 4'b0100 && !fn[0]) begin
      pushMove(fn[1] ? mipsOiscPkg::loAddr : mipsOiscPkg::hiAddr, regD); // MFHI, MFLO
    end else if (opc == 6'h00 && rt == 5'd0 && rd == 5'd0 && sh == 5'd0 &&
                 fn[5:2] == 4'b0100 && fn[0]) begin
      pushMove(regS, fn[1] ? mipsOiscPkg::loAddr : mipsOiscPkg::hiAddr); // MTHI, MTLO
    end else if (opc == 6'h0f && rs == 5'd0) begin
      pushMove(imm, mipsOiscPkg::immAddr);
      pushMove(mipsOiscPkg::immAddr, mipsOiscPkg::luiBase);
      pushMove(mipsOiscPkg::luiBase + 16'd3, regT);
    end else begin
      pushMove(16'h0000, 16'h0000);
    end
  endtask

  initial begin : stimulus
    logic        dropValid;
    logic        stalled;
    logic [31:0] heldMove;
    logic [31:0] expMove;
    int          accepted;
    CLK       = 1'b0;
    RST       = 1'b1;
    inValid   = 1'b0;
    inData    = '0;
    outReady  = 1'b0;
    errors    = 0;
    checks    = 0;
    dropValid = 1'b0;
    stalled   = 1'b0;
    heldMove  = '0;
    accepted  = 0;
    void'($urandom(32'hd437));
    repeat (5) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b0;
    checkValue("inReady", 32'(inReady), 32'd1);
    checkValue("outValid", 32'(outValid), 32'd0);

    while (accepted < numInstr || expQ.size() != 0) begin
      @(negedge CLK);
      if (dropValid) begin
        inValid   = 1'b0;
        dropValid = 1'b0;
      end
      // DUT state must follow the pending expected moves
      checkValue("inReady", 32'(inReady), 32'(expQ.size() == 0));
      checkValue("outValid", 32'(outValid), 32'(expQ.size() != 0));
      if (stalled) begin
        checkValue("outData", outData, heldMove);
      end

      if (!inValid && accepted < numInstr && ($urandom % 4) != 0) begin
        inData  = randomInstr();
        inValid = 1'b1;
      end
      outReady = ($urandom % 2) == 1;

      // What the coming rising edge transfers
      if (inValid && inReady) begin
        buildExpected(inData);
        accepted++;
        dropValid = 1'b1;
      end
      stalled  = outValid && !outReady;
      heldMove = outData;
      if (outValid && outReady && expQ.size() != 0) begin
        expMove = expQ.pop_front();
        checkValue("outData", outData, expMove);
      end
    end

    @(negedge CLK);
    checkValue("inReady", 32'(inReady), 32'd1);
    checkValue("outValid", 32'(outValid), 32'd0);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  initial begin : watchdog
    #(watchdogNs);
    $display("Timeout: the run did not finish within %0d ns", watchdogNs);
    $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: translateControl.sv
`timescale 1ns/10ps
`default_nettype none

module translateControl (
  input  logic                  CLK,
  input  logic                  RST,

  input  logic                  inValid,
  output logic                  inReady,
  input  mipsOiscPkg::mipsInstr inData,

  output logic                  outValid,
  input  logic                  outReady,

  input  mipsOiscPkg::stepIdx   stepCount,
  output mipsOiscPkg::mipsInstr instr,
  output mipsOiscPkg::stepIdx   step
);

  logic busy;
  logic accept;
  logic xfer;
  logic lastXfer;

  assign inReady  = ~busy;
  assign outValid = busy;

  assign accept   = inValid & inReady;
  assign xfer     = outValid & outReady;
  assign lastXfer = xfer & (step == 3'(stepCount - 3'd1));

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy <= 1'b0;
    end else if (accept) begin
      busy <= 1'b1;
    end else if (lastXfer) begin
      busy <= 1'b0; // inReady rises with the final move
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      instr <= '0;
    end else if (accept) begin
      instr <= inData;
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      step <= '0;
    end else if (accept || lastXfer) begin
      step <= '0;
    end else if (xfer) begin
      step <= step + 3'd1;
    end
  end

  stepCountBounded: assert property (
    @(posedge CLK) disable iff (RST) busy |-> (stepCount <= mipsOiscPkg::maxSteps)
  );

  stepInRange: assert property (
    @(posedge CLK) disable iff (RST) busy |-> (step < stepCount)
  );

  // Move word must not change while the sink stalls
  holdUnderStall: assert property (
    @(posedge CLK) disable iff (RST)
      (outValid && !outReady) |=> ($stable(instr) && $stable(step))
  );

endmodule

`default_nettype wire
